// File: Bender.yml
package:
  name: mipsCore

sources:
  - logic/isaPkg.sv
  - logic/corePkg.sv
  - logic/stageIf.sv
  - logic/fetchDecode.sv
  - logic/aluExecute.sv
  - logic/resultWriteback.sv
  - logic/mipsCore.sv
  - target: test
    files:
      - dv/tbMipsCore.sv

// File: dv/coreCases.txt
// program words at 0xbfc00000 upward, then data words, then trace rows
// trace row columns: pc, register number, write data, writes-register flag
@00
3c011234 34218765 2402fffd 00221821
00412023 00232824 00823026 0041382a
00074100 8d090004 01215021 ac0a0008
8c0b0008 00220021 fc000000 000b6025
// initial data words at byte addresses 0x00 to 0x1c
@10
11111111 22222222 33333333 44444444
55555555 0badf00d 77777777 88888888
@18
bfc00000 00000001 12340000 00000001
bfc00004 00000001 12348765 00000001
bfc00008 00000002 fffffffd 00000001
bfc0000c 00000003 12348762 00000001
bfc00010 00000004 edcb7898 00000001
bfc00014 00000005 12348760 00000001
bfc00018 00000006 12348765 00000001
bfc0001c 00000007 00000001 00000001
bfc00020 00000008 00000010 00000001
bfc00024 00000009 0badf00d 00000001
bfc00028 0000000a 1de27772 00000001
bfc0002c 00000000 00000000 00000000
bfc00030 0000000b 1de27772 00000001
bfc00034 00000000 00000000 00000000
bfc00038 00000000 00000000 00000000
bfc0003c 0000000c 1de27772 00000001

// File: dv/tbMipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module tbMipsCore;
	import corePkg::*;

	localparam wordT RESET_PC = 32'hbfc00000;
	localparam int PROG_WORDS = 16;
	localparam int DATA_WORDS = 8;
	localparam int TRACE_ROWS = 16;
	localparam int TRACE_BASE = PROG_WORDS + DATA_WORDS;
	localparam int CASE_WORDS = TRACE_BASE + 4 * TRACE_ROWS;
	localparam int WAIT_LIMIT = 64;

	logic clk;
	logic arstN_i;
	wordT instSramRdata_i;
	wordT dataSramRdata_i;
	logic instSramEn_o;
	logic [WEN_W-1:0] instSramWen_o;
	wordT instSramAddr_o;
	wordT instSramWdata_o;
	logic dataSramEn_o;
	logic [WEN_W-1:0] dataSramWen_o;
	wordT dataSramAddr_o;
	wordT dataSramWdata_o;
	wordT debugWbPc_o;
	logic [WEN_W-1:0] debugWbRfWen_o;
	regAddrT debugWbRfWnum_o;
	wordT debugWbRfWdata_o;

	wordT caseMem [CASE_WORDS];
	wordT progMem [PROG_WORDS];
	wordT dataMem [DATA_WORDS];

	// requests seen in the current cycle
	logic instReqEn;
	wordT instReqAddr;
	logic dataReqEn;
	logic [WEN_W-1:0] dataReqWen;
	wordT dataReqAddr;
	wordT dataReqWdata;

	int errorCount;
	int checkCount;
	int timeoutCount;

	mipsCore #(
		.RESET_PC(RESET_PC)
	) dut (
		.clk(clk),
		.arstN_i(arstN_i),
		.instSramRdata_i(instSramRdata_i),
		.dataSramRdata_i(dataSramRdata_i),
		.instSramEn_o(instSramEn_o),
		.instSramWen_o(instSramWen_o),
		.instSramAddr_o(instSramAddr_o),
		.instSramWdata_o(instSramWdata_o),
		.dataSramEn_o(dataSramEn_o),
		.dataSramWen_o(dataSramWen_o),
		.dataSramAddr_o(dataSramAddr_o),
		.dataSramWdata_o(dataSramWdata_o),
		.debugWbPc_o(debugWbPc_o),
		.debugWbRfWen_o(debugWbRfWen_o),
		.debugWbRfWnum_o(debugWbRfWnum_o),
		.debugWbRfWdata_o(debugWbRfWdata_o)
	);

	always #4 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// SRAM models
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// past the program the core fetches sll r0 words
	function automatic wordT fetchWord(wordT addr);
		wordT offset;
		offset = addr - RESET_PC;
		if (offset[31:2] < PROG_WORDS) begin
			return progMem[offset[31:2]];
		end
		return '0;
	endfunction

	function automatic wordT loadWord(wordT addr);
		if (addr[31:5] == '0) begin
			return dataMem[addr[4:2]];
		end
		return addr ^ 32'h5a5aa5a5;
	endfunction

	// requests are stable by the falling edge
	always @(negedge clk) begin
		instReqEn = instSramEn_o;
		instReqAddr = instSramAddr_o;
		dataReqEn = dataSramEn_o;
		dataReqWen = dataSramWen_o;
		dataReqAddr = dataSramAddr_o;
		dataReqWdata = dataSramWdata_o;
	end

	always @(posedge clk) begin
		#1;
		if (instReqEn) begin
			instSramRdata_i = fetchWord(instReqAddr);
		end
		if (dataReqEn) begin
			if (dataReqWen != '0) begin
				// stores are whole words
				assert (dataReqWen === {WEN_W{1'b1}}) else begin
					$display("CHECK FAILED t=%0t dataSramWen_o expected %h got %h",
						$time, {WEN_W{1'b1}}, dataReqWen);
					errorCount++;
				end
				if (dataReqAddr[31:5] == '0) begin
					dataMem[dataReqAddr[4:2]] = dataReqWdata;
				end
			end else begin
				dataSramRdata_i = loadWord(dataReqAddr);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// trace checker
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a nonzero pc on the trace marks a retirement
	task automatic awaitRetirement(output int waited, output logic arrived);
		waited = 0;
		arrived = 1'b0;
		while (!arrived && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
			arrived = (debugWbPc_o !== '0);
		end
	endtask

	task automatic checkRetirement(int row, int waited);
		wordT expPc;
		wordT expNum;
		wordT expData;
		logic expWrite;
		logic [WEN_W-1:0] expWen;
		expPc = caseMem[TRACE_BASE + 4 * row];
		expNum = caseMem[TRACE_BASE + 4 * row + 1];
		expData = caseMem[TRACE_BASE + 4 * row + 2];
		expWrite = caseMem[TRACE_BASE + 4 * row + 3][0];
		expWen = expWrite ? '1 : '0;
		checkCount++;
		assert (debugWbPc_o === expPc) else begin
			$display("CHECK FAILED t=%0t debugWbPc_o expected %h got %h",
				$time, expPc, debugWbPc_o);
			errorCount++;
		end
		assert (debugWbRfWen_o === expWen) else begin
			$display("CHECK FAILED t=%0t debugWbRfWen_o expected %h got %h",
				$time, expWen, debugWbRfWen_o);
			errorCount++;
		end
		// instruction port is read only
		assert (instSramWen_o === '0) else begin
			$display("CHECK FAILED t=%0t instSramWen_o expected %h got %h",
				$time, {WEN_W{1'b0}}, instSramWen_o);
			errorCount++;
		end
		assert (instSramWdata_o === '0) else begin
			$display("CHECK FAILED t=%0t instSramWdata_o expected %h got %h",
				$time, 32'h0, instSramWdata_o);
			errorCount++;
		end
		if (row > 0) begin
			assert (waited == 1) else begin
				$display("retirement %0d came %0d cycles after the one before it",
					row, waited);
				errorCount++;
			end
		end
		if (expWrite) begin
			assert (debugWbRfWnum_o === expNum[4:0]) else begin
				$display("CHECK FAILED t=%0t debugWbRfWnum_o expected %0d got %0d",
					$time, expNum[4:0], debugWbRfWnum_o);
				errorCount++;
			end
			assert (debugWbRfWdata_o === expData) else begin
				$display("CHECK FAILED t=%0t debugWbRfWdata_o expected %h got %h",
					$time, expData, debugWbRfWdata_o);
				errorCount++;
			end
		end
	endtask

	initial begin
		int i;
		int row;
		int waited;
		logic arrived;
		clk = 1'b0;
		arstN_i = 1'b0;
		instSramRdata_i = '0;
		dataSramRdata_i = '0;
		instReqEn = 1'b0;
		dataReqEn = 1'b0;
		errorCount = 0;
		checkCount = 0;
		timeoutCount = 0;

		$readmemh("dv/coreCases.txt", caseMem);
		assert (!$isunknown(caseMem[CASE_WORDS-1])) else begin
			$display("the cases file dv/coreCases.txt could not be read in full");
			errorCount++;
		end
		for (i = 0; i < PROG_WORDS; i++) begin
			progMem[i] = caseMem[i];
		end
		for (i = 0; i < DATA_WORDS; i++) begin
			dataMem[i] = caseMem[PROG_WORDS + i];
		end

		repeat (16) @(posedge clk);
		#1;
		arstN_i = 1'b1;

		row = 0;
		arrived = 1'b1;
		while (arrived && row < TRACE_ROWS) begin
			awaitRetirement(waited, arrived);
			if (arrived) begin
				checkRetirement(row, waited);
				row++;
			end else begin
				$display("retirement %0d did not arrive within %0d cycles", row, WAIT_LIMIT);
				timeoutCount++;
			end
		end

		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/aluExecute.sv
`timescale 1ns/100ps
`default_nettype none

module aluExecute (
	input logic clk,
	input logic arstN_i,
	decExIf.consumer decEx,
	input logic wbWe_i,
	input corePkg::regAddrT wbAddr_i,
	input corePkg::wordT wbData_i,
	output logic dataSramEn_o,
	output logic [corePkg::WEN_W-1:0] dataSramWen_o,
	output corePkg::wordT dataSramAddr_o,
	output corePkg::wordT dataSramWdata_o,
	exResIf.producer exRes
);
	import corePkg::*;
	import isaPkg::*;

	wordT rsFwd;
	wordT rtFwd;
	wordT extImm;
	wordT opB;
	wordT aluRes;
	logic [15:0] imm16;

	// result of the instruction now retiring
	function automatic wordT forward(regAddrT src, wordT regVal);
		return (wbWe_i && src != '0 && wbAddr_i == src) ? wbData_i : regVal;
	endfunction

	assign rsFwd = forward(decEx.payload.rs, decEx.payload.rsVal);
	assign rtFwd = forward(decEx.payload.rt, decEx.payload.rtVal);

	// ori zero-extends, the rest sign-extend
	assign imm16 = decEx.payload.imm[15:0];
	assign extImm = (decEx.payload.aluOp == ALU_OR) ? wordT'(imm16) :
		{{(XLEN-16){imm16[15]}}, imm16};
	assign opB = decEx.payload.useImm ? extImm : rtFwd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (decEx.payload.aluOp)
			ALU_ADD: aluRes = rsFwd + opB;
			ALU_SUB: aluRes = rsFwd - opB;
			ALU_AND: aluRes = rsFwd & opB;
			ALU_OR: aluRes = rsFwd | opB;
			ALU_XOR: aluRes = rsFwd ^ opB;
			ALU_SLT: aluRes = wordT'($signed(rsFwd) < $signed(opB));
			ALU_SLL: aluRes = opB << decEx.payload.imm[4:0];
			ALU_LUI: aluRes = {imm16, 16'b0};
			ALU_PASS: aluRes = opB;
			default: aluRes = '0;
		endcase
	end

	// data SRAM request, whole words only
	assign dataSramEn_o = decEx.valid && (decEx.payload.memRead || decEx.payload.memWrite);
	assign dataSramWen_o = (decEx.valid && decEx.payload.memWrite) ? '1 : '0;
	assign dataSramAddr_o = aluRes;
	assign dataSramWdata_o = rtFwd;

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			exRes.valid <= 1'b0;
		end else begin
			exRes.valid <= decEx.valid;
		end
	end

	always_ff @(posedge clk) begin
		exRes.payload.pc <= decEx.payload.pc;
		exRes.payload.aluRes <= aluRes;
		exRes.payload.dest <= decEx.payload.dest;
		exRes.payload.regWrite <= decEx.payload.regWrite;
		exRes.payload.memRead <= decEx.payload.memRead;
	end

	// a store is never also a load, and writes a whole aligned word
	assert property (@(posedge clk) disable iff (!arstN_i)
		(dataSramWen_o != '0) |-> (!decEx.payload.memRead
		&& dataSramAddr_o[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: logic/corePkg.sv
`default_nettype none

package corePkg;

	localparam int XLEN = 32;
	localparam int WEN_W = 4;

	typedef logic [4:0] regAddrT;
	typedef logic [XLEN-1:0] wordT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// decode -> execute, imm holds the raw 16 bits or the shift amount
	typedef struct packed {
		wordT pc;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT dest;
		isaPkg::aluOpT aluOp;
		logic useImm;
		logic regWrite;
		logic memRead;
		logic memWrite;
	} decExT;

	// execute -> result
	typedef struct packed {
		wordT pc;
		wordT aluRes;
		regAddrT dest;
		logic regWrite;
		logic memRead;
	} exResT;

endpackage

`default_nettype wire

// File: logic/fetchDecode.sv
`timescale 1ns/100ps
`default_nettype none

module fetchDecode #(
	parameter corePkg::wordT RESET_PC = 32'hbfc00000
) (
	input logic clk,
	input logic arstN_i,
	input corePkg::wordT instSramRdata_i,
	output logic instSramEn_o,
	output corePkg::wordT instSramAddr_o,
	input logic wbWe_i,
	input corePkg::regAddrT wbAddr_i,
	input corePkg::wordT wbData_i,
	decExIf.producer decEx
);
	import corePkg::*;
	import isaPkg::*;

	logic fetchEn;
	logic decValid;
	wordT pc;
	wordT pcD;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] shamt;
	logic [15:0] imm16;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;

	wordT regFile [32];
	decExT decNext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fetch
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			fetchEn <= 1'b0;
			decValid <= 1'b0;
			pc <= RESET_PC;
		end else begin
			fetchEn <= 1'b1;
			decValid <= fetchEn;
			if (fetchEn) begin
				pc <= pc + wordT'(4);
			end
		end
	end

	// address of the word now arriving from the SRAM
	always_ff @(posedge clk) begin
		pcD <= pc;
	end

	assign instSramEn_o = fetchEn;
	assign instSramAddr_o = pc;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign opcode = instSramRdata_i[OPC_HI:OPC_LO];
	assign rs = instSramRdata_i[RS_HI:RS_LO];
	assign rt = instSramRdata_i[RT_HI:RT_LO];
	assign rd = instSramRdata_i[RD_HI:RD_LO];
	assign shamt = instSramRdata_i[SH_HI:SH_LO];
	assign funct = instSramRdata_i[FN_HI:FN_LO];
	assign imm16 = instSramRdata_i[IMM_HI:IMM_LO];

	// r0 reads zero, a same-cycle writeback wins over the array
	function automatic wordT readReg(regAddrT addr);
		wordT val;
		val = regFile[addr];
		if (addr == '0) begin
			val = '0;
		end else if (wbWe_i && wbAddr_i == addr) begin
			val = wbData_i;
		end
		return val;
	endfunction

	always_comb begin
		decNext = '0;
		decNext.pc = pcD;
		decNext.rs = rs;
		decNext.rt = rt;
		decNext.rsVal = readReg(rs);
		decNext.rtVal = readReg(rt);
		decNext.dest = rt;
		decNext.imm = wordT'(imm16);
		decNext.aluOp = ALU_PASS;
		case (opcode)
			OP_SPECIAL: begin
				decNext.dest = rd;
				decNext.imm = wordT'(shamt);
				decNext.regWrite = 1'b1;
				case (funct)
					FN_ADDU: decNext.aluOp = ALU_ADD;
					FN_SUBU: decNext.aluOp = ALU_SUB;
					FN_AND: decNext.aluOp = ALU_AND;
					FN_OR: decNext.aluOp = ALU_OR;
					FN_XOR: decNext.aluOp = ALU_XOR;
					FN_SLT: decNext.aluOp = ALU_SLT;
					FN_SLL: decNext.aluOp = ALU_SLL;
					default: decNext.regWrite = 1'b0;
				endcase
			end
			OP_ADDIU, OP_LW, OP_SW: begin
				decNext.aluOp = ALU_ADD;
				decNext.useImm = 1'b1;
				decNext.regWrite = (opcode != OP_SW);
				decNext.memRead = (opcode == OP_LW);
				decNext.memWrite = (opcode == OP_SW);
			end
			OP_ORI: begin
				decNext.aluOp = ALU_OR;
				decNext.useImm = 1'b1;
				decNext.regWrite = 1'b1;
			end
			OP_LUI: begin
				decNext.aluOp = ALU_LUI;
				decNext.useImm = 1'b1;
				decNext.regWrite = 1'b1;
			end
			// anything else leaves the no-op defaults
			default: decNext.aluOp = ALU_PASS;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wbWe_i) begin
			regFile[wbAddr_i] <= wbData_i;
		end
	end

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			decEx.valid <= 1'b0;
		end else begin
			decEx.valid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		decEx.payload <= decNext;
	end

	// the SRAM answers every enabled fetch with a clean word one cycle later
	assert property (@(posedge clk) disable iff (!arstN_i)
		decValid |-> !$isunknown(instSramRdata_i));

endmodule

`default_nettype wire

// File: logic/isaPkg.sv
`default_nettype none

package isaPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// opcodes and functs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// field bounds inside the instruction word
	localparam int OPC_HI = 31;
	localparam int OPC_LO = 26;
	localparam int RS_HI = 25;
	localparam int RS_LO = 21;
	localparam int RT_HI = 20;
	localparam int RT_LO = 16;
	localparam int RD_HI = 15;
	localparam int RD_LO = 11;
	localparam int SH_HI = 10;
	localparam int SH_LO = 6;
	localparam int FN_HI = 5;
	localparam int FN_LO = 0;
	localparam int IMM_HI = 15;
	localparam int IMM_LO = 0;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI,
		ALU_PASS
	} aluOpT;

endpackage

`default_nettype wire

// File: logic/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore #(
	parameter corePkg::wordT RESET_PC = 32'hbfc00000
) (
	input logic clk,
	input logic arstN_i,
	input corePkg::wordT instSramRdata_i,
	input corePkg::wordT dataSramRdata_i,
	output logic instSramEn_o,
	output logic [corePkg::WEN_W-1:0] instSramWen_o,
	output corePkg::wordT instSramAddr_o,
	output corePkg::wordT instSramWdata_o,
	output logic dataSramEn_o,
	output logic [corePkg::WEN_W-1:0] dataSramWen_o,
	output corePkg::wordT dataSramAddr_o,
	output corePkg::wordT dataSramWdata_o,
	output corePkg::wordT debugWbPc_o,
	output logic [corePkg::WEN_W-1:0] debugWbRfWen_o,
	output corePkg::regAddrT debugWbRfWnum_o,
	output corePkg::wordT debugWbRfWdata_o
);
	import corePkg::*;

	logic wbWe;
	regAddrT wbAddr;
	wordT wbData;

	decExIf decEx ();
	exResIf exRes ();

	// instruction port never writes
	assign instSramWen_o = '0;
	assign instSramWdata_o = '0;

	fetchDecode #(
		.RESET_PC(RESET_PC)
	) uFetchDecode (
		.clk(clk),
		.arstN_i(arstN_i),
		.instSramRdata_i(instSramRdata_i),
		.instSramEn_o(instSramEn_o),
		.instSramAddr_o(instSramAddr_o),
		.wbWe_i(wbWe),
		.wbAddr_i(wbAddr),
		.wbData_i(wbData),
		.decEx(decEx.producer)
	);

	aluExecute uAluExecute (
		.clk(clk),
		.arstN_i(arstN_i),
		.decEx(decEx.consumer),
		.wbWe_i(wbWe),
		.wbAddr_i(wbAddr),
		.wbData_i(wbData),
		.dataSramEn_o(dataSramEn_o),
		.dataSramWen_o(dataSramWen_o),
		.dataSramAddr_o(dataSramAddr_o),
		.dataSramWdata_o(dataSramWdata_o),
		.exRes(exRes.producer)
	);

	resultWriteback uResultWriteback (
		.exRes(exRes.consumer),
		.dataSramRdata_i(dataSramRdata_i),
		.wbWe_o(wbWe),
		.wbAddr_o(wbAddr),
		.wbData_o(wbData),
		.debugWbPc_o(debugWbPc_o),
		.debugWbRfWen_o(debugWbRfWen_o),
		.debugWbRfWnum_o(debugWbRfWnum_o),
		.debugWbRfWdata_o(debugWbRfWdata_o)
	);

endmodule

`default_nettype wire

// File: logic/resultWriteback.sv
`timescale 1ns/100ps
`default_nettype none

module resultWriteback (
	exResIf.consumer exRes,
	input corePkg::wordT dataSramRdata_i,
	output logic wbWe_o,
	output corePkg::regAddrT wbAddr_o,
	output corePkg::wordT wbData_o,
	output corePkg::wordT debugWbPc_o,
	output logic [corePkg::WEN_W-1:0] debugWbRfWen_o,
	output corePkg::regAddrT debugWbRfWnum_o,
	output corePkg::wordT debugWbRfWdata_o
);

	// load data arrives from the SRAM in this cycle
	assign wbData_o = exRes.payload.memRead ? dataSramRdata_i : exRes.payload.aluRes;
	assign wbAddr_o = exRes.payload.dest;
	assign wbWe_o = exRes.valid && exRes.payload.regWrite && (exRes.payload.dest != '0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// debug trace
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign debugWbPc_o = exRes.valid ? exRes.payload.pc : '0;
	assign debugWbRfWen_o = wbWe_o ? '1 : '0;
	assign debugWbRfWnum_o = wbAddr_o;
	assign debugWbRfWdata_o = wbData_o;

	// a retiring load brings a fully known word
	always_comb begin
		if (wbWe_o && exRes.payload.memRead) begin
			assert final (!$isunknown(dataSramRdata_i));
		end
	end

endmodule

`default_nettype wire

// File: logic/stageIf.sv
`timescale 1ns/100ps
`default_nettype none

// decode -> execute stage register
interface decExIf;
	import corePkg::*;

	logic valid;
	decExT payload;

	modport producer (
		output valid,
		output payload
	);

	modport consumer (
		input valid,
		input payload
	);

endinterface

// execute -> result stage register
interface exResIf;
	import corePkg::*;

	logic valid;
	exResT payload;

	modport producer (
		output valid,
		output payload
	);

	modport consumer (
		input valid,
		input payload
	);

endinterface

`default_nettype wire

// File: project.f
logic/isaPkg.sv
logic/corePkg.sv
logic/stageIf.sv
logic/fetchDecode.sv
logic/aluExecute.sv
logic/resultWriteback.sv
logic/mipsCore.sv
dv/tbMipsCore.sv
